// File: hdl/fire_expand_consts.svh
// Sizing constants for the shared fire expand-3x3 convolution engine
`ifndef FIRE_EXPAND_CONSTS_SVH
`define FIRE_EXPAND_CONSTS_SVH

////////////////////////////////////////
// Core dimensions
////////////////////////////////////////

// Output channels, one MAC lane each
`define FE_LANES 8

// 4 input channels x 3x3 window
`define FE_TAPS 36

// Output pixels per layer
`define FE_PIXELS 16

////////////////////////////////////////
// Fixed-point format
////////////////////////////////////////

// Pixel and weight width
`define FE_PIX_W 16

// Accumulator and biased sum
`define FE_ACC_W 32

// Kept slice of the biased sum, 15 bits
`define FE_SLICE_LO 14
`define FE_SLICE_HI 28

`endif

// File: hdl/fire_expand_pkg.sv
// Shared types for the fire expand engine control strobes and result bus
`include "fire_expand_consts.svh"

package fire_expand_pkg;

	// One flag per layer, used for enables, feedback and finish
	typedef struct packed {
		logic fire3;
		logic fire2;
	} fire_layer_flags_t;

	// Strobes from the window controller
	typedef struct packed {
		logic acc_en;
		logic clr;
		logic rom_rst;
		logic layer_end;
	} fire_ctrl_t;

	// One word per lane
	typedef logic [`FE_LANES-1:0][`FE_PIX_W-1:0] fire_lane_words_t;

	// Result bus, layer is 0 for fire2 and 1 for fire3
	typedef struct packed {
		logic             sample;
		logic             layer;
		fire_lane_words_t ofm;
	} fire_out_t;

	// Weight ROM tap address
	typedef logic [$clog2(`FE_TAPS)-1:0] fire_tap_t;

endpackage

// File: hdl/fire_layer_regs.sv
// Layer selection, end and feedback latches, finish flags and counter restart
`timescale 1ns/1ps

module fire_layer_regs import fire_expand_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  fire_layer_flags_t layer_en,
	input  fire_layer_flags_t ram_feedback,
	input  logic              layer_end,
	output logic              run,
	output logic              layer,
	output logic              restart,
	output fire_layer_flags_t finish
);

	logic              sel;
	logic              active;
	logic              layer_chg;
	logic              cur_ended;
	fire_layer_flags_t end_q;
	fire_layer_flags_t fb_q;

	// fire2 wins when both enables are up
	assign sel       = !layer_en.fire2;
	assign active    = layer_en.fire2 || layer_en.fire3;
	assign layer_chg = active && (sel != layer);
	assign cur_ended = layer ? end_q.fire3 : end_q.fire2;

	// Stop once the active layer is done
	assign run = active && !layer_chg && !cur_ended;

	// Clear counters on a layer switch or at the end of the running layer
	assign restart = layer_chg || layer_end;

	assign finish.fire2 = end_q.fire2 && !fb_q.fire2;
	assign finish.fire3 = end_q.fire3 && !fb_q.fire3;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			layer <= 1'b0;
		end else if (active) begin
			layer <= sel;
		end
	end

	// End latches, set by the controller strobe for the active layer
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			end_q <= '0;
		end else if (layer_end) begin
			if (layer)
				end_q.fire3 <= 1'b1;
			else
				end_q.fire2 <= 1'b1;
		end
	end

	// Feedback latches, held until reset
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			fb_q <= '0;
		end else begin
			if (ram_feedback.fire2)
				fb_q.fire2 <= 1'b1;
			if (ram_feedback.fire3)
				fb_q.fire3 <= 1'b1;
		end
	end

endmodule

// File: hdl/fire_window_ctrl.sv
// Tap counter, clear strobe, ROM address and pixel timer for the expand core
`timescale 1ns/1ps
`include "fire_expand_consts.svh"

module fire_window_ctrl import fire_expand_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       run,
	input  logic       restart,
	output fire_ctrl_t ctrl,
	output fire_tap_t  tap
);

	localparam int CNT_W = $clog2(`FE_TAPS + 1);
	localparam int PIX_CNT_W = $clog2(`FE_PIXELS + 1);

	localparam logic [CNT_W-1:0] LAST_TAP = CNT_W'(`FE_TAPS - 1);
	localparam logic [CNT_W-1:0] CLR_SLOT = CNT_W'(`FE_TAPS);
	localparam logic [PIX_CNT_W-1:0] PIX_LAST = PIX_CNT_W'(`FE_PIXELS);

	logic [CNT_W-1:0]     cnt;
	logic [PIX_CNT_W-1:0] pix_cnt;
	logic                 done;
	logic                 go;
	logic                 done_q;

	////////////////////////////////////////
	// Strobe decode
	////////////////////////////////////////

	assign done = (pix_cnt == PIX_LAST);

	// No more groups once the pixel count is reached
	assign go = run && !done;

	assign ctrl.acc_en    = go && (cnt < CLR_SLOT);
	assign ctrl.rom_rst   = go && (cnt == LAST_TAP);
	assign ctrl.clr       = go && (cnt == CLR_SLOT);
	// One cycle later than done so the last sample is out first
	assign ctrl.layer_end = run && done_q;

	////////////////////////////////////////
	// Counters
	////////////////////////////////////////

	// Taps 0..35 then one clear slot
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cnt <= '0;
		end else if (restart) begin
			cnt <= '0;
		end else if (go) begin
			if (ctrl.clr)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
		end
	end

	// ROM address wraps one slot early and waits at zero
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tap <= '0;
		end else if (restart) begin
			tap <= '0;
		end else if (ctrl.rom_rst) begin
			tap <= '0;
		end else if (ctrl.acc_en) begin
			tap <= tap + 1'b1;
		end
	end

	// Pixel timer counts finished groups
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pix_cnt <= '0;
			done_q  <= 1'b0;
		end else if (restart) begin
			pix_cnt <= '0;
			done_q  <= 1'b0;
		end else begin
			if (ctrl.clr)
				pix_cnt <= pix_cnt + 1'b1;
			if (run)
				done_q <= done;
		end
	end

endmodule

// File: hdl/fire_weight_rom.sv
// Per-layer weight and bias tables, weights read by layer and tap address
`timescale 1ns/1ps
`include "fire_expand_consts.svh"

module fire_weight_rom import fire_expand_pkg::*; (
	input  logic                        layer,
	input  fire_tap_t                   tap,
	output fire_lane_words_t            weights,
	output logic signed [`FE_ACC_W-1:0] biases [`FE_LANES]
);

	localparam int ROWS = 2 * `FE_TAPS;
	localparam int ROW_W = $clog2(ROWS);

	typedef fire_lane_words_t [ROWS-1:0] w_table_t;
	typedef logic [1:0][`FE_LANES-1:0][`FE_ACC_W-1:0] b_table_t;

	// ((7*tap + 13*lane + 5*layer) mod 31 - 15) * 256
	function automatic w_table_t build_weights();
		w_table_t t;
		int       v;
		t = '0;
		for (int l = 0; l < 2; l++) begin
			for (int k = 0; k < `FE_TAPS; k++) begin
				for (int n = 0; n < `FE_LANES; n++) begin
					v = ((k * 7 + n * 13 + l * 5) % 31 - 15) * 256;
					t[l * `FE_TAPS + k][n] = v[`FE_PIX_W-1:0];
				end
			end
		end
		return t;
	endfunction

	// 4096*lane - 16384 + 2048*layer
	function automatic b_table_t build_biases();
		b_table_t t;
		for (int l = 0; l < 2; l++) begin
			for (int n = 0; n < `FE_LANES; n++) begin
				t[l][n] = n * 4096 - 16384 + l * 2048;
			end
		end
		return t;
	endfunction

	localparam w_table_t W_TAB = build_weights();
	localparam b_table_t B_TAB = build_biases();

	logic [ROW_W-1:0] row;

	// fire3 rows follow the fire2 rows
	assign row = layer ? ROW_W'(tap) + ROW_W'(`FE_TAPS) : ROW_W'(tap);

	assign weights = W_TAB[row];

	always_comb begin
		for (int n = 0; n < `FE_LANES; n++) begin
			biases[n] = $signed(B_TAB[layer][n]);
		end
	end

endmodule

// File: hdl/fire_mac_lane.sv
// Signed multiply-accumulate lane with synchronous clear and hold
`timescale 1ns/1ps
`include "fire_expand_consts.svh"

module fire_mac_lane (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        acc_en,
	input  logic                        clr,
	input  logic signed [`FE_PIX_W-1:0] pix,
	input  logic signed [`FE_PIX_W-1:0] ker,
	output logic signed [`FE_ACC_W-1:0] acc
);

	logic signed [`FE_ACC_W-1:0] prod;

	// Full 32-bit signed product
	assign prod = pix * ker;

	////////////////////////////////////////
	// Accumulator
	////////////////////////////////////////

	// Clear wins, otherwise add or hold
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			acc <= '0;
		end else if (clr) begin
			acc <= '0;
		end else if (acc_en) begin
			acc <= acc + prod;
		end
	end

endmodule

// File: hdl/fire_requant.sv
// Bias addition, ReLU, fixed-point slice and output registers for all lanes
`timescale 1ns/1ps
`include "fire_expand_consts.svh"

module fire_requant import fire_expand_pkg::*; (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        clr,
	input  logic                        layer,
	input  logic signed [`FE_ACC_W-1:0] acc [`FE_LANES],
	input  logic signed [`FE_ACC_W-1:0] biases [`FE_LANES],
	output fire_out_t                   result
);

	logic signed [`FE_ACC_W-1:0] sum [`FE_LANES];
	fire_lane_words_t            relu;
	fire_lane_words_t            ofm_q;
	logic                        layer_q;
	logic                        sample_q;

	////////////////////////////////////////
	// Bias and ReLU
	////////////////////////////////////////

	always_comb begin
		for (int n = 0; n < `FE_LANES; n++) begin
			sum[n] = acc[n] + biases[n];
			// Negative sums go to zero, else keep bits 28..14
			if (sum[n][`FE_ACC_W-1])
				relu[n] = '0;
			else
				relu[n] = {1'b0, sum[n][`FE_SLICE_HI:`FE_SLICE_LO]};
		end
	end

	// Words and layer held until the next group
	always_ff @(posedge clk) begin
		if (clr) begin
			ofm_q   <= relu;
			layer_q <= layer;
		end
	end

	// Sample marks the cycle the new words appear
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sample_q <= 1'b0;
		end else begin
			sample_q <= clr;
		end
	end

	assign result = '{sample: sample_q, layer: layer_q, ofm: ofm_q};

endmodule

// File: hdl/fire_expand_top.sv
// Fire2/fire3 expand-3x3 engine top with control, weight ROM, MAC lanes and requantizer
`timescale 1ns/1ps
`include "fire_expand_consts.svh"

module fire_expand_top import fire_expand_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  fire_layer_flags_t     layer_en,
	input  logic [`FE_PIX_W-1:0]  ifm,
	input  fire_layer_flags_t     ram_feedback,
	output fire_out_t             result,
	output fire_layer_flags_t     finish
);

	logic                        run;
	logic                        layer;
	logic                        restart;
	fire_ctrl_t                  ctrl;
	fire_tap_t                   tap;
	fire_lane_words_t            weights;
	logic signed [`FE_ACC_W-1:0] biases [`FE_LANES];
	logic signed [`FE_ACC_W-1:0] acc [`FE_LANES];

	// Input stage
	logic [`FE_PIX_W-1:0] pix_q;
	fire_lane_words_t     ker_q;
	logic                 acc_en_q;
	logic                 clr_q;
	logic                 lane_clr_q;

	fire_layer_regs u_regs (
		.clk          (clk),
		.rst          (rst),
		.layer_en     (layer_en),
		.ram_feedback (ram_feedback),
		.layer_end    (ctrl.layer_end),
		.run          (run),
		.layer        (layer),
		.restart      (restart),
		.finish       (finish)
	);

	fire_window_ctrl u_ctrl (
		.clk     (clk),
		.rst     (rst),
		.run     (run),
		.restart (restart),
		.ctrl    (ctrl),
		.tap     (tap)
	);

	fire_weight_rom u_rom (
		.layer   (layer),
		.tap     (tap),
		.weights (weights),
		.biases  (biases)
	);

	////////////////////////////////////////
	// Pixel and weight stage
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		pix_q <= ifm;
		ker_q <= weights;
	end

	// Strobes delayed to line up with pix_q and ker_q
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			acc_en_q   <= 1'b0;
			clr_q      <= 1'b0;
			lane_clr_q <= 1'b0;
		end else begin
			acc_en_q   <= ctrl.acc_en;
			clr_q      <= ctrl.clr;
			// Partial sums are dropped on a restart as well
			lane_clr_q <= ctrl.clr || restart;
		end
	end

	for (genvar g = 0; g < `FE_LANES; g++) begin : g_lane
		fire_mac_lane u_lane (
			.clk    (clk),
			.rst    (rst),
			.acc_en (acc_en_q),
			.clr    (lane_clr_q),
			.pix    ($signed(pix_q)),
			.ker    ($signed(ker_q[g])),
			.acc    (acc[g])
		);
	end

	fire_requant u_requant (
		.clk    (clk),
		.rst    (rst),
		.clr    (clr_q),
		.layer  (layer),
		.acc    (acc),
		.biases (biases),
		.result (result)
	);

endmodule

// File: verif/fire_expand_props.sv
// Concurrent checks on the expand core control strobes and sample timing
`timescale 1ns/1ps

module fire_expand_props import fire_expand_pkg::*; (
	input logic       clk,
	input logic       rst,
	input logic       run,
	input fire_ctrl_t ctrl,
	input logic       sample
);

	// Clear strobe is a single-cycle pulse
	a_clr_pulse: assert property (@(posedge clk) disable iff (!rst)
		ctrl.clr |=> !ctrl.clr)
		else $error("clr strobe held for more than one cycle");

	// Clear slot comes right after the ROM wrap
	a_clr_after_wrap: assert property (@(posedge clk) disable iff (!rst)
		(run && $past(ctrl.rom_rst)) |-> ctrl.clr)
		else $error("clr did not follow rom_rst");

	// Sample two cycles after clear, and never otherwise
	a_sample_delay: assert property (@(posedge clk) disable iff (!rst)
		sample == $past(ctrl.clr, 2))
		else $error("sample not two cycles after clr");

	// Layer end only while running, with the tap counter stopped
	a_end_needs_run: assert property (@(posedge clk) disable iff (!rst)
		ctrl.layer_end |-> run && !ctrl.acc_en && !ctrl.clr)
		else $error("layer_end without run or while a group is still open");

endmodule

bind fire_expand_top fire_expand_props u_props (
	.clk    (clk),
	.rst    (rst),
	.run    (run),
	.ctrl   (ctrl),
	.sample (result.sample)
);

// File: verif/fire_expand_tb.sv
// Testbench for the fire expand engine with directed layer runs against a lane model
`timescale 1ns/1ps
`include "fire_expand_consts.svh"

module fire_expand_tb import fire_expand_pkg::*; ();

	localparam int PERIOD = 8;
	localparam int GROUP_CYCLES = `FE_TAPS + 1;
	// Four full layer runs plus idle, pause and handover cycles
	localparam int WATCHDOG_CYCLES = 4 * `FE_PIXELS * GROUP_CYCLES + 2000;

	logic                 clk;
	logic                 rst;
	fire_layer_flags_t    layer_en;
	fire_layer_flags_t    ram_feedback;
	logic [`FE_PIX_W-1:0] ifm;
	fire_out_t            result;
	fire_layer_flags_t    finish;

	int               seed;
	int               sample_count;
	int               cur_layer;
	int               zero_words;
	int               live_words;
	fire_lane_words_t exp_q[$];
	int               exp_layer_q[$];

	fire_expand_top dut (
		.clk          (clk),
		.rst          (rst),
		.layer_en     (layer_en),
		.ifm          (ifm),
		.ram_feedback (ram_feedback),
		.result       (result),
		.finish       (finish)
	);

	always #(PERIOD / 2) clk = ~clk;

	////////////////////////////////////////
	// Checking
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// Every sample is matched against the oldest finished group
	always @(negedge clk) begin
		if (rst && result.sample) begin
			if (exp_q.size() == 0) begin
				$display("A sample appeared with no finished pixel group to match");
				$display("Result: FAILED");
				$fatal(1, "unexpected sample");
			end else begin
				check_value("result.layer", 32'(result.layer), 32'(exp_layer_q.pop_front()));
				compare_words(exp_q.pop_front());
				sample_count++;
			end
		end
	end

	task automatic compare_words(input fire_lane_words_t exp);
		for (int n = 0; n < `FE_LANES; n++)
			check_value($sformatf("result.ofm[%0d]", n), 32'(result.ofm[n]), 32'(exp[n]));
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic int weight_of(input int l, input int k, input int n);
		return ((k * 7 + n * 13 + l * 5) % 31 - 15) * 256;
	endfunction

	function automatic int bias_of(input int l, input int n);
		return n * 4096 - 16384 + l * 2048;
	endfunction

	// ReLU, then bits 28..14 under a zero top bit
	function automatic logic [`FE_PIX_W-1:0] relu_slice(input int s);
		logic [31:0] u;
		u = s;
		if (s < 0)
			return '0;
		else
			return {1'b0, u[`FE_SLICE_HI:`FE_SLICE_LO]};
	endfunction

	function automatic fire_lane_words_t group_result(input int l, input int pix [`FE_TAPS]);
		fire_lane_words_t w;
		int               acc;
		for (int n = 0; n < `FE_LANES; n++) begin
			acc = 0;
			for (int k = 0; k < `FE_TAPS; k++)
				acc += pix[k] * weight_of(l, k, n);
			w[n] = relu_slice(acc + bias_of(l, n));
		end
		return w;
	endfunction

	function automatic fire_layer_flags_t layer_flags(input int l);
		fire_layer_flags_t f;
		f = '0;
		if (l != 0)
			f.fire3 = 1'b1;
		else
			f.fire2 = 1'b1;
		return f;
	endfunction

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	// Mode 0 is random; mode 1 follows one lane's weights, sign flipping per group
	task automatic make_pixels(input int mode, input int g, output int pix [`FE_TAPS]);
		for (int k = 0; k < `FE_TAPS; k++) begin
			if (mode == 0)
				pix[k] = int'($signed(16'($random(seed))));
			else if (g % 2 == 0)
				pix[k] = weight_of(0, k, g % `FE_LANES) / 16;
			else
				pix[k] = -weight_of(0, k, g % `FE_LANES) / 16;
		end
	endtask

	// 36 taps and one clear slot; optional pause before tap pause_at
	task automatic run_group(input int l, input int pix [`FE_TAPS], input int pause_at);
		fire_layer_flags_t en;
		fire_lane_words_t  exp;
		en = layer_flags(l);
		for (int i = 0; i <= `FE_TAPS; i++) begin
			@(posedge clk);
			if (i == pause_at) begin
				layer_en <= '0;
				repeat (5) @(posedge clk);
			end
			layer_en <= en;
			if (i < `FE_TAPS)
				ifm <= 16'(pix[i]);
			else
				ifm <= 16'($random(seed));
		end
		exp = group_result(l, pix);
		for (int n = 0; n < `FE_LANES; n++) begin
			if (exp[n] == '0)
				zero_words++;
			else
				live_words++;
		end
		exp_q.push_back(exp);
		exp_layer_q.push_back(l);
	endtask

	task automatic wait_finish(input int l);
		int n;
		n = 0;
		while (!((l != 0) ? finish.fire3 : finish.fire2)) begin
			@(negedge clk);
			n++;
			if (n > 4 * GROUP_CYCLES) begin
				$display("Finish flag of layer %0d never rose", l);
				$display("Result: FAILED");
				$fatal(1, "finish timeout");
			end
		end
		// Finish only after the last sample of the layer
		check_value("sample count", 32'(sample_count), 32'(`FE_PIXELS));
		check_value("pending groups", 32'(exp_q.size()), 32'd0);
		@(posedge clk);
		layer_en <= '0;
		sample_count = 0;
	endtask

	// A layer switch costs one restart cycle before tap 0
	task automatic run_layer(input int l, input int mode, input int pause_group);
		int pix [`FE_TAPS];
		if (l != cur_layer) begin
			@(posedge clk);
			layer_en <= layer_flags(l);
			cur_layer = l;
		end
		for (int g = 0; g < `FE_PIXELS; g++) begin
			make_pixels(mode, g, pix);
			run_group(l, pix, (g == pause_group) ? `FE_TAPS / 2 : -1);
		end
		wait_finish(l);
	endtask

	task automatic reset_dut();
		@(posedge clk);
		rst          <= 1'b0;
		layer_en     <= '0;
		ram_feedback <= '0;
		ifm          <= '0;
		repeat (2) @(posedge clk);
		rst <= 1'b1;
		cur_layer = 0;
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_idle();
		repeat (20) begin
			@(negedge clk);
			check_value("result.sample", 32'(result.sample), 32'd0);
			check_value("finish", 32'(finish), 32'd0);
		end
	endtask

	task automatic test_fire2_random();
		run_layer(0, 0, -1);
	endtask

	task automatic test_fire3_switch();
		run_layer(1, 0, -1);
		check_value("finish.fire2", 32'(finish.fire2), 32'd1);
	endtask

	task automatic test_negative_lanes();
		zero_words = 0;
		live_words = 0;
		run_layer(0, 1, -1);
		// Pattern must give both clipped and live lanes
		check_value("clipped lanes present", 32'(zero_words > 0), 32'd1);
		check_value("live lanes present", 32'(live_words > 0), 32'd1);
	endtask

	task automatic test_pause();
		run_layer(1, 0, 6);
	endtask

	task automatic test_feedback();
		@(negedge clk);
		check_value("finish", 32'(finish), 32'd3);
		@(posedge clk);
		ram_feedback <= layer_flags(0);
		@(posedge clk);
		ram_feedback <= '0;
		@(negedge clk);
		check_value("finish.fire2", 32'(finish.fire2), 32'd0);
		check_value("finish.fire3", 32'(finish.fire3), 32'd1);
		repeat (10) @(negedge clk);
		check_value("finish.fire2", 32'(finish.fire2), 32'd0);
		@(posedge clk);
		ram_feedback <= layer_flags(1);
		@(posedge clk);
		ram_feedback <= '0;
		@(negedge clk);
		check_value("finish", 32'(finish), 32'd0);
	endtask

	////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////

	initial begin
		clk          = 1'b0;
		rst          = 1'b0;
		layer_en     = '0;
		ram_feedback = '0;
		ifm          = '0;
		seed         = 32'h1bd63b55;
		sample_count = 0;
		cur_layer    = 0;
		zero_words   = 0;
		live_words   = 0;
		repeat (2) @(posedge clk);
		rst <= 1'b1;
		test_idle();
		test_fire2_random();
		test_fire3_switch();
		reset_dut();
		test_negative_lanes();
		test_pause();
		test_feedback();
		$display("Result: PASSED");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("Simulation timed out before all tests completed");
		$display("Result: FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: fire_expand.f
+incdir+hdl
hdl/fire_expand_pkg.sv
hdl/fire_layer_regs.sv
hdl/fire_window_ctrl.sv
hdl/fire_weight_rom.sv
hdl/fire_mac_lane.sv
hdl/fire_requant.sv
hdl/fire_expand_top.sv
verif/fire_expand_props.sv
verif/fire_expand_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = fire_expand_tb
FILELIST  = fire_expand.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build and run; a $fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
